// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ex_top
FILELIST = ex_subsys.f

.PHONY: sim clean

# pass only if the run prints the pass message
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Result: PASSED" > /dev/null

clean:
	rm -rf obj_dir

// ==== common/ex_pkg.sv ====
package ex_pkg;

    // datapath widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int funct_w    = 6;
    localparam int shamt_w    = 5;

    // mult/div timing
    localparam int div_cycles  = 32;
    localparam int mult_cycles = 2;
    localparam int md_cnt_w    = $clog2(div_cycles + 1);

    // SPECIAL function field
    localparam logic [funct_w-1:0] funct_sll   = 6'h00;
    localparam logic [funct_w-1:0] funct_srl   = 6'h02;
    localparam logic [funct_w-1:0] funct_sra   = 6'h03;
    localparam logic [funct_w-1:0] funct_sllv  = 6'h04;
    localparam logic [funct_w-1:0] funct_srlv  = 6'h06;
    localparam logic [funct_w-1:0] funct_srav  = 6'h07;
    localparam logic [funct_w-1:0] funct_movz  = 6'h0a;
    localparam logic [funct_w-1:0] funct_movn  = 6'h0b;
    localparam logic [funct_w-1:0] funct_mfhi  = 6'h10;
    localparam logic [funct_w-1:0] funct_mthi  = 6'h11;
    localparam logic [funct_w-1:0] funct_mflo  = 6'h12;
    localparam logic [funct_w-1:0] funct_mtlo  = 6'h13;
    localparam logic [funct_w-1:0] funct_mult  = 6'h18;
    localparam logic [funct_w-1:0] funct_multu = 6'h19;
    localparam logic [funct_w-1:0] funct_div   = 6'h1a;
    localparam logic [funct_w-1:0] funct_divu  = 6'h1b;
    localparam logic [funct_w-1:0] funct_add   = 6'h20;
    localparam logic [funct_w-1:0] funct_addu  = 6'h21;
    localparam logic [funct_w-1:0] funct_sub   = 6'h22;
    localparam logic [funct_w-1:0] funct_subu  = 6'h23;
    localparam logic [funct_w-1:0] funct_and   = 6'h24;
    localparam logic [funct_w-1:0] funct_or    = 6'h25;
    localparam logic [funct_w-1:0] funct_xor   = 6'h26;
    localparam logic [funct_w-1:0] funct_nor   = 6'h27;
    localparam logic [funct_w-1:0] funct_slt   = 6'h2a;
    localparam logic [funct_w-1:0] funct_sltu  = 6'h2b;

    // SPECIAL2 ops moved into free SPECIAL slots
    localparam logic [funct_w-1:0] funct2_mul   = 6'h1c;
    localparam logic [funct_w-1:0] funct2_madd  = 6'h1d;
    localparam logic [funct_w-1:0] funct2_maddu = 6'h1e;
    localparam logic [funct_w-1:0] funct2_msub  = 6'h1f;
    localparam logic [funct_w-1:0] funct2_msubu = 6'h2c;
    localparam logic [funct_w-1:0] funct2_clz   = 6'h2d;
    localparam logic [funct_w-1:0] funct2_clo   = 6'h2e;

    typedef struct packed {
        logic [data_w-1:0] hi;
        logic [data_w-1:0] lo;
    } hilo_parts_t;

    // same 64 bits seen as one product or as the hi/lo pair
    typedef union packed {
        logic [2*data_w-1:0] full;
        hilo_parts_t         parts;
    } hilo_word_u;

endpackage

// ==== ex_stage/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu (
    input  logic [ex_pkg::funct_w-1:0] funct,
    input  logic [ex_pkg::shamt_w-1:0] shamt,
    input  logic [ex_pkg::data_w-1:0]  operand_1,
    input  logic [ex_pkg::data_w-1:0]  operand_2,
    input  logic                       write_reg_en_in,
    input  ex_pkg::hilo_word_u         hilo,
    output logic [ex_pkg::data_w-1:0]  result,
    output logic                       write_reg_en,
    output logic                       overflow,
    output logic                       hilo_write_en,
    output ex_pkg::hilo_word_u         hilo_next
);

    logic                          subtract;
    logic [ex_pkg::data_w-1:0]     operand_2_mux;
    logic [ex_pkg::data_w-1:0]     sum;
    logic                          overflow_sum;
    logic                          less_than;
    logic [ex_pkg::data_w-1:0]     count;
    logic                          mul_signed;
    logic [2*ex_pkg::data_w-1:0]   ext_1;
    logic [2*ex_pkg::data_w-1:0]   ext_2;
    logic [2*ex_pkg::data_w-1:0]   product;

    assign subtract      = (funct == ex_pkg::funct_sub) || (funct == ex_pkg::funct_subu);
    assign operand_2_mux = subtract ? ~operand_2 + 1'b1 : operand_2;
    assign sum           = operand_1 + operand_2_mux;

    // operand 2 sign as added, which covers a 0x80000000 subtrahend
    assign overflow_sum = (operand_1[ex_pkg::data_w-1] == (operand_2[ex_pkg::data_w-1] ^ subtract))
                          && (sum[ex_pkg::data_w-1] != operand_1[ex_pkg::data_w-1]);
    assign overflow = ((funct == ex_pkg::funct_add) || (funct == ex_pkg::funct_sub))
                      && overflow_sum;

    assign less_than = (funct == ex_pkg::funct_slt) ? ($signed(operand_1) < $signed(operand_2))
                                                    : (operand_1 < operand_2);

    bit_counter bit_counter0 (
        .funct     (funct),
        .operand_1 (operand_1),
        .count     (count)
    );

    // single-cycle product for MUL and the accumulate ops
    assign mul_signed = (funct != ex_pkg::funct2_maddu) && (funct != ex_pkg::funct2_msubu);
    assign ext_1   = {{ex_pkg::data_w{mul_signed && operand_1[ex_pkg::data_w-1]}}, operand_1};
    assign ext_2   = {{ex_pkg::data_w{mul_signed && operand_2[ex_pkg::data_w-1]}}, operand_2};
    assign product = ext_1 * ext_2;

    always_comb begin
        case (funct)
            ex_pkg::funct_and:  result = operand_1 & operand_2;
            ex_pkg::funct_or:   result = operand_1 | operand_2;
            ex_pkg::funct_xor:  result = operand_1 ^ operand_2;
            ex_pkg::funct_nor:  result = ~(operand_1 | operand_2);
            ex_pkg::funct_slt, ex_pkg::funct_sltu:
                result = {{(ex_pkg::data_w-1){1'b0}}, less_than};
            ex_pkg::funct_add, ex_pkg::funct_addu,
            ex_pkg::funct_sub, ex_pkg::funct_subu:  result = sum;
            ex_pkg::funct_movn, ex_pkg::funct_movz: result = operand_1;
            ex_pkg::funct2_clz, ex_pkg::funct2_clo: result = count;
            ex_pkg::funct2_mul: result = product[ex_pkg::data_w-1:0];
            ex_pkg::funct_mfhi: result = hilo.parts.hi;
            ex_pkg::funct_mflo: result = hilo.parts.lo;
            ex_pkg::funct_sll:  result = operand_2 << shamt;
            ex_pkg::funct_srl:  result = operand_2 >> shamt;
            ex_pkg::funct_sra:  result = $signed(operand_2) >>> shamt;
            ex_pkg::funct_sllv: result = operand_2 << operand_1[ex_pkg::shamt_w-1:0];
            ex_pkg::funct_srlv: result = operand_2 >> operand_1[ex_pkg::shamt_w-1:0];
            ex_pkg::funct_srav: result = $signed(operand_2) >>> operand_1[ex_pkg::shamt_w-1:0];
            default:            result = '0;
        endcase
    end

    always_comb begin
        case (funct)
            ex_pkg::funct_add, ex_pkg::funct_sub:
                write_reg_en = write_reg_en_in && !overflow_sum;
            // ops that only touch HI/LO
            ex_pkg::funct_mult, ex_pkg::funct_multu, ex_pkg::funct_div, ex_pkg::funct_divu,
            ex_pkg::funct_mthi, ex_pkg::funct_mtlo,
            ex_pkg::funct2_madd, ex_pkg::funct2_maddu,
            ex_pkg::funct2_msub, ex_pkg::funct2_msubu: write_reg_en = 1'b0;
            ex_pkg::funct_movn: write_reg_en = (operand_2 != '0);
            ex_pkg::funct_movz: write_reg_en = (operand_2 == '0);
            default:            write_reg_en = write_reg_en_in;
        endcase
    end

    always_comb begin
        hilo_next     = hilo;
        hilo_write_en = 1'b1;
        case (funct)
            ex_pkg::funct_mthi: hilo_next.parts.hi = operand_1;
            ex_pkg::funct_mtlo: hilo_next.parts.lo = operand_1;
            ex_pkg::funct2_madd, ex_pkg::funct2_maddu: hilo_next.full = hilo.full + product;
            ex_pkg::funct2_msub, ex_pkg::funct2_msubu: hilo_next.full = hilo.full - product;
            // mult/div results arrive from the multi-cycle unit
            default: hilo_write_en = 1'b0;
        endcase
    end

endmodule

// ==== ex_subsys.f ====
common/ex_pkg.sv
hw/bit_counter.sv
hw/hilo_regs.sv
mult_div/mult_div_unit.sv
ex_stage/ex_alu.sv
hw/ex_top.sv
tests/tb_ex_top.sv

// ==== hw/bit_counter.sv ====
`timescale 1ns/1ps

module bit_counter (
    input  logic [ex_pkg::funct_w-1:0] funct,
    input  logic [ex_pkg::data_w-1:0]  operand_1,
    output logic [ex_pkg::data_w-1:0]  count
);

    logic [ex_pkg::data_w-1:0] scan;
    logic                      found;

    // CLO counts ones, so flip and count zeros
    assign scan = (funct == ex_pkg::funct2_clo) ? ~operand_1 : operand_1;

    // first set bit from the top
    always_comb begin
        count = 32'(ex_pkg::data_w);
        found = 1'b0;
        for (int i = ex_pkg::data_w - 1; i >= 0; i--) begin
            if (!found && scan[i]) begin
                count = 32'(ex_pkg::data_w - 1 - i);
                found = 1'b1;
            end
        end
    end

endmodule

// ==== hw/ex_top.sv ====
`timescale 1ns/1ps

module ex_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [ex_pkg::funct_w-1:0]    funct,
    input  logic [ex_pkg::shamt_w-1:0]    shamt,
    input  logic [ex_pkg::data_w-1:0]     operand_1,
    input  logic [ex_pkg::data_w-1:0]     operand_2,
    input  logic                          write_reg_en_in,
    input  logic [ex_pkg::reg_addr_w-1:0] write_reg_addr_in,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [ex_pkg::data_w-1:0]     result,
    output logic                          write_reg_en,
    output logic [ex_pkg::reg_addr_w-1:0] write_reg_addr,
    output logic                          overflow
);

    logic                          accept;
    logic                          is_md;
    logic                          md_start;
    logic                          md_busy;
    logic                          md_done;
    logic                          md_pending;
    logic [ex_pkg::reg_addr_w-1:0] md_addr;
    logic [ex_pkg::data_w-1:0]     alu_result;
    logic                          alu_write_reg_en;
    logic                          alu_overflow;
    logic                          alu_hilo_we;
    ex_pkg::hilo_word_u            hilo;
    ex_pkg::hilo_word_u            hilo_next;
    ex_pkg::hilo_word_u            md_hilo;

    assign is_md = (funct == ex_pkg::funct_mult) || (funct == ex_pkg::funct_multu) ||
                   (funct == ex_pkg::funct_div)  || (funct == ex_pkg::funct_divu);

    // output slot free or draining, and no mult/div outstanding
    assign in_ready = (!out_valid || out_ready) && !md_busy && !md_pending;
    assign accept   = in_valid && in_ready;
    assign md_start = accept && is_md;

    ex_alu alu0 (
        .funct           (funct),
        .shamt           (shamt),
        .operand_1       (operand_1),
        .operand_2       (operand_2),
        .write_reg_en_in (write_reg_en_in),
        .hilo            (hilo),
        .result          (alu_result),
        .write_reg_en    (alu_write_reg_en),
        .overflow        (alu_overflow),
        .hilo_write_en   (alu_hilo_we),
        .hilo_next       (hilo_next)
    );

    hilo_regs hilo0 (
        .clk          (clk),
        .rst          (rst),
        .alu_write_en (accept && alu_hilo_we),
        .alu_hilo     (hilo_next),
        .md_done      (md_done),
        .md_hilo      (md_hilo),
        .hilo         (hilo)
    );

    mult_div_unit md0 (
        .clk       (clk),
        .rst       (rst),
        .start     (md_start),
        .funct     (funct),
        .operand_1 (operand_1),
        .operand_2 (operand_2),
        .busy      (md_busy),
        .done      (md_done),
        .md_hilo   (md_hilo)
    );

    // pending flag covers the done cycle too
    always_ff @(posedge clk) begin
        if (rst) begin
            md_pending <= 1'b0;
        end else if (md_start) begin
            md_pending <= 1'b1;
        end else if (md_done) begin
            md_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            md_addr <= write_reg_addr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if ((accept && !is_md) || md_done) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // slot is always empty when md_done fires
    always_ff @(posedge clk) begin
        if (accept && !is_md) begin
            result         <= alu_result;
            write_reg_en   <= alu_write_reg_en;
            write_reg_addr <= write_reg_addr_in;
            overflow       <= alu_overflow;
        end else if (md_done) begin
            result         <= '0;
            write_reg_en   <= 1'b0;
            write_reg_addr <= md_addr;
            overflow       <= 1'b0;
        end
    end

    out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(result) &&
            $stable(write_reg_en) && $stable(write_reg_addr) && $stable(overflow)));

endmodule

// ==== hw/hilo_regs.sv ====
`timescale 1ns/1ps

module hilo_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_write_en,
    input  ex_pkg::hilo_word_u alu_hilo,
    input  logic               md_done,
    input  ex_pkg::hilo_word_u md_hilo,
    output ex_pkg::hilo_word_u hilo
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hilo <= '0;
        end else if (md_done) begin
            hilo <= md_hilo;
        end else if (alu_write_en) begin
            hilo <= alu_hilo;
        end
    end

    // top holds off new ops until a mult/div result is retired
    write_excl: assert property (@(posedge clk) disable iff (rst)
        !(md_done && alu_write_en));

endmodule

// ==== mult_div/mult_div_unit.sv ====
`timescale 1ns/1ps

module mult_div_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [ex_pkg::funct_w-1:0] funct,
    input  logic [ex_pkg::data_w-1:0]  operand_1,
    input  logic [ex_pkg::data_w-1:0]  operand_2,
    output logic                       busy,
    output logic                       done,
    output ex_pkg::hilo_word_u         md_hilo
);

    logic                          start_div;
    logic                          start_signed;
    logic [ex_pkg::data_w-1:0]     abs_1;
    logic [ex_pkg::data_w-1:0]     abs_2;
    logic [ex_pkg::md_cnt_w-1:0]   cnt;
    logic                          is_div;
    logic                          is_signed;
    // dividend shifts out of op_a while quotient bits shift in
    logic [ex_pkg::data_w-1:0]     op_a;
    logic [ex_pkg::data_w-1:0]     op_b;
    logic [ex_pkg::data_w-1:0]     rem;
    logic                          neg_q;
    logic                          neg_r;
    logic [2*ex_pkg::data_w-1:0]   ext_a;
    logic [2*ex_pkg::data_w-1:0]   ext_b;
    logic [2*ex_pkg::data_w-1:0]   prod;
    logic [ex_pkg::data_w:0]       shifted;
    logic [ex_pkg::data_w+1:0]     diff;

    assign start_div    = (funct == ex_pkg::funct_div) || (funct == ex_pkg::funct_divu);
    assign start_signed = (funct == ex_pkg::funct_div) || (funct == ex_pkg::funct_mult);
    assign abs_1 = (start_signed && operand_1[ex_pkg::data_w-1]) ? -operand_1 : operand_1;
    assign abs_2 = (start_signed && operand_2[ex_pkg::data_w-1]) ? -operand_2 : operand_2;

    // low 64 bits of the extended product suit both signed and unsigned
    assign ext_a = {{ex_pkg::data_w{is_signed && op_a[ex_pkg::data_w-1]}}, op_a};
    assign ext_b = {{ex_pkg::data_w{is_signed && op_b[ex_pkg::data_w-1]}}, op_b};

    // restoring step with the top bit of diff as the borrow
    assign shifted = {rem, op_a[ex_pkg::data_w-1]};
    assign diff    = {1'b0, shifted} - {2'b00, op_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= start_div ? ex_pkg::md_cnt_w'(ex_pkg::div_cycles)
                                  : ex_pkg::md_cnt_w'(ex_pkg::mult_cycles - 1);
            end else if (busy) begin
                if (cnt == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div    <= start_div;
            is_signed <= start_signed && !start_div;
            op_a      <= start_div ? abs_1 : operand_1;
            op_b      <= start_div ? abs_2 : operand_2;
            rem       <= '0;
            // divide by zero keeps all-ones quotient and the dividend
            neg_q <= start_signed && (operand_1[ex_pkg::data_w-1] ^ operand_2[ex_pkg::data_w-1])
                     && (operand_2 != '0);
            neg_r <= start_signed && operand_1[ex_pkg::data_w-1];
        end else if (busy && cnt != '0) begin
            if (is_div) begin
                rem  <= diff[ex_pkg::data_w+1] ? shifted[ex_pkg::data_w-1:0]
                                               : diff[ex_pkg::data_w-1:0];
                op_a <= {op_a[ex_pkg::data_w-2:0], !diff[ex_pkg::data_w+1]};
            end else begin
                prod <= ext_a * ext_b;
            end
        end else if (busy) begin
            if (is_div) begin
                md_hilo.parts.hi <= neg_r ? -rem : rem;
                md_hilo.parts.lo <= neg_q ? -op_a : op_a;
            end else begin
                md_hilo.full <= prod;
            end
        end
    end

    no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== tests/ex_patterns.txt ====
# funct shamt operand_1 operand_2 write_reg_en_in | result write_reg_en overflow
# all fields hex, one operation per line, HI/LO carries over between lines
24 00 f0f0f0f0 ff00ff00 1 f000f000 1 0
25 00 f0f0f0f0 0f0f0000 1 fffff0f0 1 0
26 00 aaaaaaaa ffff0000 0 5555aaaa 0 0
27 00 12345678 0000ffff 1 edcb0000 1 0
00 04 00000000 80000001 1 00000010 1 0
02 08 00000000 80000000 1 00800000 1 0
03 08 00000000 80000000 1 ff800000 1 0
04 00 00000024 0000000f 1 000000f0 1 0
06 00 0000001f ffffffff 1 00000001 1 0
07 00 00000004 f0000000 1 ff000000 1 0
2a 00 ffffffff 00000001 1 00000001 1 0
2b 00 ffffffff 00000001 1 00000000 1 0
20 00 7fffffff 00000001 1 80000000 0 1
21 00 7fffffff 00000001 1 80000000 1 0
22 00 80000000 00000001 1 7fffffff 0 1
23 00 00000005 00000007 1 fffffffe 1 0
0b 00 deadbeef 00000001 1 deadbeef 1 0
0a 00 deadbeef 00000001 1 deadbeef 0 0
2d 00 00000000 00000000 1 00000020 1 0
2e 00 ffffffff 00000000 1 00000020 1 0
2d 00 00010000 00000000 1 0000000f 1 0
1c 00 fffffffe 00000003 1 fffffffa 1 0
1a 00 fffffff9 00000002 1 00000000 0 0
10 00 00000000 00000000 1 ffffffff 1 0
12 00 00000000 00000000 1 fffffffd 1 0
1b 00 00000005 00000000 1 00000000 0 0
10 00 00000000 00000000 1 00000005 1 0
12 00 00000000 00000000 1 ffffffff 1 0
18 00 fffffffd 00000007 1 00000000 0 0
10 00 00000000 00000000 1 ffffffff 1 0
12 00 00000000 00000000 1 ffffffeb 1 0
11 00 00000000 00000000 1 00000000 0 0
13 00 00000010 00000000 1 00000000 0 0
1d 00 00000003 00000004 1 00000000 0 0
1f 00 fffffffe 00000010 1 00000000 0 0
1e 00 ffffffff 00000002 1 00000000 0 0
10 00 00000000 00000000 1 00000002 1 0
12 00 00000000 00000000 1 0000003a 1 0

// ==== tests/tb_ex_top.sv ====
`timescale 1ns/1ps

module tb_ex_top;

    localparam int max_tests  = 64;
    localparam int wait_limit = 200;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic                          in_ready;
    logic [ex_pkg::funct_w-1:0]    funct;
    logic [ex_pkg::shamt_w-1:0]    shamt;
    logic [ex_pkg::data_w-1:0]     operand_1;
    logic [ex_pkg::data_w-1:0]     operand_2;
    logic                          write_reg_en_in;
    logic [ex_pkg::reg_addr_w-1:0] write_reg_addr_in;
    logic                          out_valid;
    logic                          out_ready;
    logic [ex_pkg::data_w-1:0]     result;
    logic                          write_reg_en;
    logic [ex_pkg::reg_addr_w-1:0] write_reg_addr;
    logic                          overflow;

    // one row per pattern line
    logic [31:0] pat_funct  [max_tests];
    logic [31:0] pat_shamt  [max_tests];
    logic [31:0] pat_op1    [max_tests];
    logic [31:0] pat_op2    [max_tests];
    logic [31:0] pat_wen    [max_tests];
    logic [31:0] exp_result [max_tests];
    logic [31:0] exp_wen    [max_tests];
    logic [31:0] exp_ovf    [max_tests];

    // pattern indices in the order they were accepted
    int     issued[$];
    int     n_tests;
    int     n_checked;
    int     n_passed;
    int     n_failed;
    integer seed = 32'h7f14;

    ex_top dut0 (
        .clk               (clk),
        .rst               (rst),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .funct             (funct),
        .shamt             (shamt),
        .operand_1         (operand_1),
        .operand_2         (operand_2),
        .write_reg_en_in   (write_reg_en_in),
        .write_reg_addr_in (write_reg_addr_in),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .result            (result),
        .write_reg_en      (write_reg_en),
        .write_reg_addr    (write_reg_addr),
        .overflow          (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure, ready about three cycles in four
    always @(negedge clk) begin
        out_ready = ($random(seed) & 3) != 0;
    end

    // every output handshake retires the oldest accepted pattern
    always @(posedge clk) begin
        int   idx;
        logic bad;
        if (!rst && out_valid && out_ready) begin
            if (issued.size() == 0) begin
                $display("an output appeared with no operation outstanding");
                n_failed++;
            end else begin
                idx = issued.pop_front();
                bad = 1'b0;
                if (result !== exp_result[idx]) begin
                    $display("[ERROR] test %0d result expected %h got %h",
                             idx, exp_result[idx], result);
                    bad = 1'b1;
                end
                if (write_reg_en !== exp_wen[idx][0]) begin
                    $display("[ERROR] test %0d write_reg_en expected %h got %h",
                             idx, exp_wen[idx][0], write_reg_en);
                    bad = 1'b1;
                end
                if (overflow !== exp_ovf[idx][0]) begin
                    $display("[ERROR] test %0d overflow expected %h got %h",
                             idx, exp_ovf[idx][0], overflow);
                    bad = 1'b1;
                end
                if (write_reg_addr !== 5'(idx)) begin
                    $display("[ERROR] test %0d write_reg_addr expected %h got %h",
                             idx, 5'(idx), write_reg_addr);
                    bad = 1'b1;
                end
                if (bad) begin
                    n_failed++;
                end else begin
                    n_passed++;
                end
                $display("test %0d funct %h %s", idx, pat_funct[idx][5:0],
                         bad ? "failed" : "ok");
                n_checked++;
            end
        end
    end

    initial begin
        int          fd;
        int          code;
        int          cycles;
        logic        accepted;
        string       line;
        logic [31:0] v [8];
        rst               = 1'b1;
        in_valid          = 1'b0;
        funct             = '0;
        shamt             = '0;
        operand_1         = '0;
        operand_2         = '0;
        write_reg_en_in   = 1'b0;
        write_reg_addr_in = '0;
        out_ready         = 1'b0;
        n_tests           = 0;
        n_checked         = 0;
        n_passed          = 0;
        n_failed          = 0;

        fd = $fopen("tests/ex_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tests/ex_patterns.txt");
            $display("Result: FAILED");
            $finish;
        end
        while (!$feof(fd) && n_tests < max_tests) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                               v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (code == 8) begin
                    pat_funct[n_tests]  = v[0];
                    pat_shamt[n_tests]  = v[1];
                    pat_op1[n_tests]    = v[2];
                    pat_op2[n_tests]    = v[3];
                    pat_wen[n_tests]    = v[4];
                    exp_result[n_tests] = v[5];
                    exp_wen[n_tests]    = v[6];
                    exp_ovf[n_tests]    = v[7];
                    n_tests++;
                end
            end
        end
        $fclose(fd);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_tests; i++) begin
            @(negedge clk);
            in_valid          = 1'b1;
            funct             = pat_funct[i][5:0];
            shamt             = pat_shamt[i][4:0];
            operand_1         = pat_op1[i];
            operand_2         = pat_op2[i];
            write_reg_en_in   = pat_wen[i][0];
            write_reg_addr_in = 5'(i);
            accepted          = 1'b0;
            cycles            = 0;
            while (!accepted && cycles < wait_limit) begin
                @(posedge clk);
                if (in_ready) begin
                    accepted = 1'b1;
                end else begin
                    cycles++;
                end
            end
            if (!accepted) begin
                $display("timed out waiting for in_ready on test %0d", i);
                $display("Result: FAILED");
                $finish;
            end
            issued.push_back(i);
        end
        @(negedge clk);
        in_valid = 1'b0;

        cycles = 0;
        while (n_checked < n_tests && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (n_checked < n_tests) begin
            $display("timed out waiting for results, %0d of %0d arrived", n_checked, n_tests);
            $display("Result: FAILED");
            $finish;
        end
        // a few idle cycles to catch a repeated output
        repeat (8) @(posedge clk);

        $display("tests %0d, passed %0d, failed %0d", n_tests, n_passed, n_failed);
        if (n_tests > 0 && n_failed == 0 && n_passed == n_tests) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
